//--- snes_mem_bridge.f
+incdir+testbench
hw/snes_bus_pkg.sv
hw/sdram_port_pkg.sv
hw/sdram_req_if.sv
hw/rom_load_tracker.sv
hw/snes_bus_decode.sv
hw/sdram_port_arbiter.sv
hw/snes_mem_bridge.sv
testbench/tb_snes_mem_bridge.sv

//--- Bender.yml
package:
  name: snes_mem_bridge

sources:
  # packages before the modules that import them
  - hw/snes_bus_pkg.sv
  - hw/sdram_port_pkg.sv
  - hw/sdram_req_if.sv
  - hw/rom_load_tracker.sv
  - hw/snes_bus_decode.sv
  - hw/sdram_port_arbiter.sv
  - hw/snes_mem_bridge.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_snes_mem_bridge.sv

//--- testbench/mem_bridge_vectors.svh
// vector rows for the memory bridge testbench, included into its table loader task
// columns: ctl, dat, rom_addr, wram_addr, resp, expected sdram_addr, expected sdram_din
// expected columns hold the registered outputs seen while that row is applied
// load a four byte image, writes trail valid by one cycle
add_row(11'b10_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b0000_00, 23'h000000, 16'h0000);
add_row(11'b11_00_00_10_111, 8'ha5, 24'h000000, 17'h00000, 6'b0000_00, 23'h000000, 16'h0000);
add_row(11'b11_00_00_10_111, 8'h3c, 24'h000000, 17'h00000, 6'b0010_01, 23'h000000, 16'ha5a5);
add_row(11'b11_00_00_10_111, 8'h5a, 24'h000000, 17'h00000, 6'b0010_10, 23'h000001, 16'h3c3c);
add_row(11'b10_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b0010_01, 23'h000002, 16'h5a5a);
add_row(11'b11_00_00_10_111, 8'hc3, 24'h000000, 17'h00000, 6'b0000_00, 23'h000000, 16'h0000);
// loading falls, loaded next cycle, enable one after that
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b0010_10, 23'h000003, 16'hc3c3);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b0000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
// busy then frame pause each drop enable for one cycle
add_row(11'b00_10_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b0000_00, 23'h000000, 16'h0000);
add_row(11'b00_01_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b0000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
// rom word read, fall strobe then request two cycles later
add_row(11'b00_00_10_01_111, 8'h00, 24'h123456, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_01_111, 8'h00, 24'h123456, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1100_11, 23'h123456, 16'h0000);
// rom selected without fall strobe, odd byte read swaps lanes
add_row(11'b00_00_00_00_111, 8'h00, 24'h000101, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_00_111, 8'h00, 24'h000102, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);
// wram read at odd address on port 1
add_row(11'b00_00_10_10_001, 8'h00, 24'h000000, 17'h12345, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_001, 8'h00, 24'h000000, 17'h12345, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1101_10, 23'h7f2345, 16'h0000);
// wram write at even address on the rise phase
add_row(11'b00_00_01_10_010, 8'h9e, 24'h000000, 17'h00010, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_010, 8'h9e, 24'h000000, 17'h00010, 6'b1000_00, 23'h000000, 16'h0000);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1011_01, 23'h7e0010, 16'h9e9e);
add_row(11'b00_00_00_10_111, 8'h00, 24'h000000, 17'h00000, 6'b1000_00, 23'h000000, 16'h0000);

//--- testbench/tb_snes_mem_bridge.sv
// self-checking testbench for the snes memory bridge, runs the vector table and prints a verdict
module tb_snes_mem_bridge;
    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    localparam int CLK_PERIOD = 40;

    // one table row
    // ctl bits: loading valid busy frame_pause f r rom_ce_n rom_word wram_ce_n wram_rd_n wram_we_n
    // resp bits: core_enable rd wr port ds[1:0]
    typedef struct packed {
        logic [10:0] ctl;
        byte_t       dat;
        rom_addr_t   rom_addr;
        wram_addr_t  wram_addr;
        logic [5:0]  resp;
        sdram_addr_t addr;
        word_t       din;
    } vec_t;

    logic        wclk;
    logic        resetn;
    logic        loading;
    logic        loader_valid;
    byte_t       loader_data;
    logic        busy;
    logic        frame_pause;
    logic        core_enable;
    logic        core_resetn;
    logic        sysclkf_ce;
    logic        sysclkr_ce;
    logic        rom_ce_n;
    logic        rom_word;
    rom_addr_t   rom_addr;
    word_t       rom_q;
    logic        wram_ce_n;
    logic        wram_rd_n;
    logic        wram_we_n;
    wram_addr_t  wram_addr;
    byte_t       wram_d;
    byte_t       wram_q;
    word_t       port0;
    word_t       port1;
    sdram_addr_t sdram_addr;
    word_t       sdram_din;
    byte_en_t    sdram_ds;
    port_sel_t   sdram_port;
    logic        sdram_rd;
    logic        sdram_wr;

    vec_t   vectors[$];
    integer seed = 32'h546b_3907;
    int     cycle_cnt = 0;
    int     cycle_limit = 0;
    int     row_idx = 0;

    snes_mem_bridge #(
        .wram_base(WRAM_BASE_DEFAULT)
    ) snes_mem_bridge_i (
        .wclk        (wclk),
        .resetn      (resetn),
        .loading     (loading),
        .loader_valid(loader_valid),
        .loader_data (loader_data),
        .busy        (busy),
        .frame_pause (frame_pause),
        .core_enable (core_enable),
        .core_resetn (core_resetn),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .rom_ce_n    (rom_ce_n),
        .rom_word    (rom_word),
        .rom_addr    (rom_addr),
        .rom_q       (rom_q),
        .wram_ce_n   (wram_ce_n),
        .wram_rd_n   (wram_rd_n),
        .wram_we_n   (wram_we_n),
        .wram_addr   (wram_addr),
        .wram_d      (wram_d),
        .wram_q      (wram_q),
        .port0       (port0),
        .port1       (port1),
        .sdram_addr  (sdram_addr),
        .sdram_din   (sdram_din),
        .sdram_ds    (sdram_ds),
        .sdram_port  (sdram_port),
        .sdram_rd    (sdram_rd),
        .sdram_wr    (sdram_wr)
    );

    always #(CLK_PERIOD / 2) wclk = ~wclk;

    // run limit from the table length
    always @(posedge wclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            fail_run("timeout before the vector table finished");
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_addr(input string name, input sdram_addr_t got, input sdram_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s row %0d: got %h expected %h", name, row_idx, got, exp));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s row %0d: got %h expected %h", name, row_idx, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s row %0d: got %h expected %h", name, row_idx, got, exp));
        end
    endtask

    task automatic check_ds(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s row %0d: got %h expected %h", name, row_idx, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch %s row %0d: got %h expected %h", name, row_idx, got, exp));
        end
    endtask

    task automatic add_row(
        input logic [10:0] ctl,
        input byte_t       dat,
        input rom_addr_t   raddr,
        input wram_addr_t  waddr,
        input logic [5:0]  resp,
        input sdram_addr_t addr,
        input word_t       din
    );
        vec_t v;
        v = {ctl, dat, raddr, waddr, resp, addr, din};
        vectors.push_back(v);
    endtask

    task automatic load_table;
        `include "mem_bridge_vectors.svh"
    endtask

    // dat feeds both the loader byte and the wram write byte
    task automatic apply_row(input vec_t v);
        {loading, loader_valid, busy, frame_pause, sysclkf_ce, sysclkr_ce,
            rom_ce_n, rom_word, wram_ce_n, wram_rd_n, wram_we_n} <= v.ctl;
        loader_data <= v.dat;
        wram_d      <= v.dat;
        rom_addr    <= v.rom_addr;
        wram_addr   <= v.wram_addr;
    endtask

    task automatic check_row(input vec_t v, input word_t p0, input word_t p1);
        word_t exp_rom_q;
        byte_t exp_wram_q;
        // word read or even byte read keeps lane order
        if (v.ctl[3] || !v.rom_addr[0]) begin
            exp_rom_q = p0;
        end else begin
            exp_rom_q = {p0[7:0], p0[15:8]};
        end
        // wram byte from the lane picked by bit 0
        exp_wram_q = v.wram_addr[0] ? p1[15:8] : p1[7:0];
        check_bit("core_enable", core_enable, v.resp[5]);
        // core reset follows loading directly
        check_bit("core_resetn", core_resetn, ~v.ctl[10]);
        check_bit("sdram_rd", sdram_rd, v.resp[4]);
        check_bit("sdram_wr", sdram_wr, v.resp[3]);
        check_bit("sdram_port", sdram_port, v.resp[2]);
        check_ds("sdram_ds", sdram_ds, v.resp[1:0]);
        check_addr("sdram_addr", sdram_addr, v.addr);
        check_word("sdram_din", sdram_din, v.din);
        check_word("rom_q", rom_q, exp_rom_q);
        check_byte("wram_q", wram_q, exp_wram_q);
    endtask

    initial begin
        word_t p0;
        word_t p1;
        wclk         = 1'b0;
        resetn       = 1'b0;
        loading      = 1'b0;
        loader_valid = 1'b0;
        loader_data  = '0;
        busy         = 1'b0;
        frame_pause  = 1'b0;
        sysclkf_ce   = 1'b0;
        sysclkr_ce   = 1'b0;
        rom_ce_n     = 1'b1;
        rom_word     = 1'b0;
        rom_addr     = '0;
        wram_ce_n    = 1'b1;
        wram_rd_n    = 1'b1;
        wram_we_n    = 1'b1;
        wram_addr    = '0;
        wram_d       = '0;
        port0        = '0;
        port1        = '0;
        load_table();
        cycle_limit = vectors.size() + 20;
        // reset for 4 cycles
        repeat (4) @(posedge wclk);
        resetn <= 1'b1;
        for (int i = 0; i < vectors.size(); i++) begin
            @(posedge wclk);
            p0 = word_t'($random(seed));
            p1 = word_t'($random(seed));
            apply_row(vectors[i]);
            port0 <= p0;
            port1 <= p1;
            // outputs settled mid cycle
            @(negedge wclk);
            row_idx = i;
            check_row(vectors[i], p0, p1);
        end
        @(posedge wclk);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- hw/snes_mem_bridge.sv
// top of the snes memory bridge, connect core strobes and sdram controller port here
module snes_mem_bridge #(
    parameter logic [5:0] wram_base = snes_bus_pkg::WRAM_BASE_DEFAULT
) (
    input  logic                        wclk,
    input  logic                        resetn,
    // cartridge loader
    input  logic                        loading,
    input  logic                        loader_valid,
    input  snes_bus_pkg::byte_t         loader_data,
    // run control
    input  logic                        busy,
    input  logic                        frame_pause,
    output logic                        core_enable,
    output logic                        core_resetn,
    // snes core bus
    input  logic                        sysclkf_ce,
    input  logic                        sysclkr_ce,
    input  logic                        rom_ce_n,
    input  logic                        rom_word,
    input  snes_bus_pkg::rom_addr_t     rom_addr,
    output snes_bus_pkg::word_t         rom_q,
    input  logic                        wram_ce_n,
    input  logic                        wram_rd_n,
    input  logic                        wram_we_n,
    input  snes_bus_pkg::wram_addr_t    wram_addr,
    input  snes_bus_pkg::byte_t         wram_d,
    output snes_bus_pkg::byte_t         wram_q,
    // sdram controller port
    input  snes_bus_pkg::word_t         port0,
    input  snes_bus_pkg::word_t         port1,
    output sdram_port_pkg::sdram_addr_t sdram_addr,
    output snes_bus_pkg::word_t         sdram_din,
    output sdram_port_pkg::byte_en_t    sdram_ds,
    output sdram_port_pkg::port_sel_t   sdram_port,
    output logic                        sdram_rd,
    output logic                        sdram_wr
);
    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    // loader write toward the arbiter
    logic        load_wr;
    sdram_addr_t load_addr;
    byte_t       load_data;

    // bus request toward the arbiter
    sdram_req_if req_if ();

    rom_load_tracker rom_load_tracker_i (
        .wclk        (wclk),
        .resetn      (resetn),
        .loading     (loading),
        .loader_valid(loader_valid),
        .loader_data (loader_data),
        .busy        (busy),
        .frame_pause (frame_pause),
        .load_wr     (load_wr),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .core_enable (core_enable),
        .core_resetn (core_resetn)
    );

    snes_bus_decode #(
        .wram_base(wram_base)
    ) snes_bus_decode_i (
        .wclk       (wclk),
        .resetn     (resetn),
        .core_enable(core_enable),
        .sysclkf_ce (sysclkf_ce),
        .sysclkr_ce (sysclkr_ce),
        .rom_ce_n   (rom_ce_n),
        .rom_word   (rom_word),
        .rom_addr   (rom_addr),
        .wram_ce_n  (wram_ce_n),
        .wram_rd_n  (wram_rd_n),
        .wram_we_n  (wram_we_n),
        .wram_addr  (wram_addr),
        .wram_d     (wram_d),
        .port0      (port0),
        .port1      (port1),
        .rom_q      (rom_q),
        .wram_q     (wram_q),
        .req        (req_if.producer)
    );

    sdram_port_arbiter sdram_port_arbiter_i (
        .wclk      (wclk),
        .resetn    (resetn),
        .req       (req_if.consumer),
        .load_wr   (load_wr),
        .load_addr (load_addr),
        .load_data (load_data),
        .sdram_addr(sdram_addr),
        .sdram_din (sdram_din),
        .sdram_ds  (sdram_ds),
        .sdram_port(sdram_port),
        .sdram_rd  (sdram_rd),
        .sdram_wr  (sdram_wr)
    );

endmodule

//--- hw/sdram_port_arbiter.sv
// merges loader writes and bus requests into the one registered sdram controller request
module sdram_port_arbiter (
    input  logic                        wclk,
    input  logic                        resetn,
    sdram_req_if.consumer               req,
    input  logic                        load_wr,
    input  sdram_port_pkg::sdram_addr_t load_addr,
    input  snes_bus_pkg::byte_t         load_data,
    output sdram_port_pkg::sdram_addr_t sdram_addr,
    output snes_bus_pkg::word_t         sdram_din,
    output sdram_port_pkg::byte_en_t    sdram_ds,
    output sdram_port_pkg::port_sel_t   sdram_port,
    output logic                        sdram_rd,
    output logic                        sdram_wr
);
    import sdram_port_pkg::*;

    // loader byte lane from address bit 0
    byte_en_t load_ds;

    assign load_ds = {load_addr[0], ~load_addr[0]};

    always_ff @(posedge wclk) begin
        // strobes last one cycle, fields return to zero
        sdram_addr <= '0;
        sdram_din  <= '0;
        sdram_ds   <= '0;
        sdram_port <= 1'b0;
        sdram_rd   <= 1'b0;
        sdram_wr   <= 1'b0;
        if (resetn) begin
            if (load_wr) begin
                // loader first, core is in reset anyway
                sdram_addr <= load_addr;
                sdram_din  <= {load_data, load_data};
                sdram_ds   <= load_ds;
                sdram_wr   <= 1'b1;
            end else if (req.rd || req.wr) begin
                sdram_addr <= req.addr;
                sdram_din  <= req.din;
                sdram_ds   <= req.ds;
                sdram_port <= req.port;
                sdram_rd   <= req.rd;
                sdram_wr   <= req.wr;
            end
        end
    end

    // controller sees one command per cycle
    a_rd_wr_onehot: assert property (
        @(posedge wclk) disable iff (!resetn)
        !(sdram_rd && sdram_wr)
    );

    // idle cycles carry a clean zero address
    a_idle_addr_zero: assert property (
        @(posedge wclk) disable iff (!resetn)
        !(sdram_rd || sdram_wr) |-> sdram_addr == '0
    );

endmodule

//--- hw/snes_bus_decode.sv
// turns snes rom and work ram strobes into sdram requests and steers returned words back
module snes_bus_decode #(
    parameter logic [5:0] wram_base = snes_bus_pkg::WRAM_BASE_DEFAULT
) (
    input  logic                     wclk,
    input  logic                     resetn,
    input  logic                     core_enable,
    input  logic                     sysclkf_ce,
    input  logic                     sysclkr_ce,
    input  logic                     rom_ce_n,
    input  logic                     rom_word,
    input  snes_bus_pkg::rom_addr_t  rom_addr,
    input  logic                     wram_ce_n,
    input  logic                     wram_rd_n,
    input  logic                     wram_we_n,
    input  snes_bus_pkg::wram_addr_t wram_addr,
    input  snes_bus_pkg::byte_t      wram_d,
    input  snes_bus_pkg::word_t      port0,
    input  snes_bus_pkg::word_t      port1,
    output snes_bus_pkg::word_t      rom_q,
    output snes_bus_pkg::byte_t      wram_q,
    sdram_req_if.producer            req
);
    import sdram_port_pkg::*;

    // fall and rise phase, one cycle after the core's clock enables
    logic fall_ph;
    logic rise_ph;
    logic rom_rd;
    logic wram_rd;
    logic wram_wr;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            fall_ph <= 1'b0;
            rise_ph <= 1'b0;
        end else begin
            fall_ph <= sysclkf_ce & core_enable;
            rise_ph <= sysclkr_ce & core_enable;
        end
    end

    // rom reads go out on the fall phase
    assign rom_rd  = ~rom_ce_n & fall_ph;
    // wram reads on fall, writes on rise
    assign wram_rd = ~wram_ce_n & ~wram_rd_n & fall_ph;
    assign wram_wr = ~wram_ce_n & ~wram_we_n & rise_ph & ~wram_rd;

    always_comb begin
        // idle request is all zero
        req.addr = '0;
        req.din  = '0;
        req.ds   = '0;
        req.port = 1'b0;
        req.rd   = 1'b0;
        req.wr   = 1'b0;
        if (rom_rd) begin
            // full word on port 0, byte picked on return
            req.addr = rom_addr[SDRAM_ADDR_W-1:0];
            req.ds   = 2'b11;
            req.rd   = 1'b1;
        end else if (wram_rd || wram_wr) begin
            req.addr = {wram_base, wram_addr};
            // odd address is the upper byte
            req.ds   = {wram_addr[0], ~wram_addr[0]};
            req.din  = {wram_d, wram_d};
            req.port = 1'b1;
            req.rd   = wram_rd;
            req.wr   = wram_wr;
        end
    end

    // odd byte read wants the high byte in the low lane
    assign rom_q = (rom_word || !rom_addr[0]) ? port0 : {port0[7:0], port0[15:8]};

    // byte lane by address bit 0
    assign wram_q = wram_addr[0] ? port1[15:8] : port1[7:0];

    // the core never selects rom and work ram together
    a_ce_exclusive: assert property (
        @(posedge wclk) disable iff (!resetn)
        !(!rom_ce_n && !wram_ce_n)
    );

endmodule

//--- hw/rom_load_tracker.sv
// follows the cartridge loader stream and derives core enable and core reset from it
module rom_load_tracker (
    input  logic                        wclk,
    input  logic                        resetn,
    input  logic                        loading,
    input  logic                        loader_valid,
    input  snes_bus_pkg::byte_t         loader_data,
    input  logic                        busy,
    input  logic                        frame_pause,
    output logic                        load_wr,
    output sdram_port_pkg::sdram_addr_t load_addr,
    output snes_bus_pkg::byte_t         load_data,
    output logic                        core_enable,
    output logic                        core_resetn
);
    import snes_bus_pkg::*;
    import sdram_port_pkg::*;

    // previous loading, for edge detect
    logic      loading_d;
    logic      loaded;
    // byte counter of the image being loaded
    rom_addr_t load_cnt;

    // each loader byte becomes a write at the current count
    assign load_wr   = loading & loader_valid;
    assign load_addr = load_cnt[SDRAM_ADDR_W-1:0];
    assign load_data = loader_data;

    // core held in reset for the whole load
    assign core_resetn = resetn & ~loading;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_d   <= 1'b0;
            loaded      <= 1'b0;
            core_enable <= 1'b0;
        end else begin
            loading_d <= loading;
            // run only when memory is idle and video is in sync
            core_enable <= ~busy & ~frame_pause & loaded;
            if (loading && !loading_d) begin
                loaded <= 1'b0;
            end else if (!loading && loading_d) begin
                // image complete
                loaded <= 1'b1;
            end
        end
    end

    // restart from zero on a new load, otherwise step per byte
    always_ff @(posedge wclk) begin
        if (loading && !loading_d) begin
            load_cnt <= '0;
        end else if (load_wr) begin
            load_cnt <= load_cnt + rom_addr_t'(1);
        end
    end

    // loader bytes outside a load would be dropped silently
    a_valid_in_load: assert property (
        @(posedge wclk) disable iff (!resetn)
        loader_valid |-> loading
    );

endmodule

//--- hw/sdram_req_if.sv
// one sdram request from the bus decoder to the port arbiter, rd and wr are single-cycle
interface sdram_req_if;
    import sdram_port_pkg::*;
    import snes_bus_pkg::*;

    sdram_addr_t addr;
    word_t       din;
    byte_en_t    ds;
    port_sel_t   port;
    // at most one strobe high, no acknowledge
    logic        rd;
    logic        wr;

    // decoder side
    modport producer (output addr, din, ds, port, rd, wr);

    // arbiter side
    modport consumer (input addr, din, ds, port, rd, wr);

endinterface

//--- hw/sdram_port_pkg.sv
// types of the single sdram request port, shared by every module of the memory bridge
package sdram_port_pkg;

    // byte address width toward the controller
    localparam int SDRAM_ADDR_W = 23;

    // byte address, bit 0 only picks the byte strobe
    typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;

    // byte strobes, upper then lower
    typedef logic [1:0] byte_en_t;

    // controller read port
    // 0 serves rom, 1 serves work ram
    typedef logic port_sel_t;

endpackage

//--- hw/snes_bus_pkg.sv
// snes side address and data types plus work ram placement, imported by the bridge modules
package snes_bus_pkg;

    // rom byte address as driven by the core
    typedef logic [23:0] rom_addr_t;

    // work ram byte address, 128 KB
    typedef logic [16:0] wram_addr_t;

    // single data byte on the snes bus
    typedef logic [7:0] byte_t;

    // sdram word as seen by the core
    typedef logic [15:0] word_t;

    // upper sdram address bits holding work ram
    // all ones puts it at the top of the 8 MB space (banks 7e/7f)
    localparam logic [5:0] WRAM_BASE_DEFAULT = 6'b111111;

endpackage
